// ==== source/aluPkg.sv ====
package aluPkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int wordBitsL   = 16;  // Datapath word
  localparam int opcodeBitsL = 8;   // Opcode field
  localparam int shiftBitsL  = 4;   // Shift amount bits taken from B

  typedef logic [wordBitsL-1:0] wordT;

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////

  // Low three bits always zero
  typedef enum logic [opcodeBitsL-1:0] {
    opAdd    = 8'd0,
    opAddi   = 8'd8,
    opAddu   = 8'd16,
    opAddui  = 8'd24,
    opAddc   = 8'd32,
    opAddcu  = 8'd40,
    opAddcui = 8'd48,
    opAddci  = 8'd56,   // A plus stored carry, B unused
    opSub    = 8'd64,
    opSubi   = 8'd72,
    opCmp    = 8'd80,
    opCmpi   = 8'd88,
    opAnd    = 8'd96,
    opOr     = 8'd104,
    opXor    = 8'd112,
    opNot    = 8'd120,  // Inverts A only
    opLsh    = 8'd128,
    opLshi   = 8'd136,
    opRsh    = 8'd144,  // Logical right
    opRshi   = 8'd152,
    opAlsh   = 8'd160,  // Same as LSH, zero fill
    opArsh   = 8'd168,  // Sign-filling right
    opNop    = 8'd176   // Keeps result and flags
  } opcodeE;

  ////////////////////////////////////////
  // Flags and port payloads
  ////////////////////////////////////////

  // MSB first, matches the old 5-bit flag vector
  typedef struct packed {
    logic zf;  // Zero
    logic cf;  // Carry out of the top bit
    logic ff;  // Signed overflow
    logic lf;  // Unsigned less-than
    logic nf;  // Signed less-than
  } flagsT;

  // One operation from the requester
  typedef struct packed {
    opcodeE opcode;
    wordT   a;
    wordT   b;
  } aluReqT;

  // Registered answer on ack
  typedef struct packed {
    wordT  c;
    flagsT flags;
  } aluRespT;

  // What each execution unit offers to the merge stage
  typedef struct packed {
    logic  hit;    // Unit owns this opcode
    logic  keep;   // Leave previous response untouched
    wordT  c;
    flagsT flags;
  } unitResultT;

endpackage

// ==== source/opLatch.sv ====
`timescale 1ns/1ps

module opLatch
  import aluPkg::*;
(
  input  logic   clk,
  input  logic   arstN,
  input  logic   req,      // Four-phase request
  input  aluReqT reqData,  // Held stable while req is high
  input  logic   ack,      // Back from flagMerge
  output aluReqT curReq,   // Operation under execution
  output logic   start     // One-cycle launch pulse
);

  typedef enum logic [1:0] {
    stIdle,      // Waiting for a new request
    stBusy,      // Operation launched, ack pending
    stWaitDrop   // Acked, requester still holds req
  } latchStateE;

  latchStateE state;
  logic       reqQ;    // req seen on the previous edge
  logic       launch;

  ////////////////////////////////////////
  // Request sampling
  ////////////////////////////////////////

  // One edge of delay before capture, gives the fixed 2-cycle latency
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      reqQ <= 1'b0;
    else
      reqQ <= req;
  end

  assign launch = (state == stIdle) && reqQ && req;

  ////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      state <= stIdle;
      start <= 1'b0;
    end
    else
    begin
      start <= launch;  // Single pulse per request
      case (state)
        stIdle:
        begin
          if (launch)
            state <= stBusy;
        end
        stBusy:
        begin
          if (ack)
            state <= stWaitDrop;  // Result is out
        end
        stWaitDrop:
        begin
          // A held req must not start twice
          if (!req)
            state <= stIdle;
        end
        default: state <= stIdle;
      endcase
    end
  end

  // Operation register
  always_ff @(posedge clk)
  begin
    if (launch)
      curReq <= reqData;
  end

endmodule

// ==== source/arithUnit.sv ====
`timescale 1ns/1ps

module arithUnit
  import aluPkg::*;
(
  input  aluReqT     curReq,
  input  logic       carryIn,  // Stored C flag
  output unitResultT res
);

  logic signedForm;    // Add or subtract, reports F
  logic unsignedForm;  // Unsigned add, reports C
  logic useCarry;      // Adds stored carry
  logic dropB;         // B replaced by zero
  logic isSub;         // A plus ~B plus 1
  logic isCmp;         // Flags only

  wordT               opB;     // Second adder input
  logic               cinEff;  // Adder carry-in
  logic [wordBitsL:0] sum;     // Top bit is carry out
  wordT               sumW;
  logic               ovf;

  ////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////

  always_comb
  begin
    signedForm   = 1'b0;
    unsignedForm = 1'b0;
    useCarry     = 1'b0;
    dropB        = 1'b0;
    isSub        = 1'b0;
    isCmp        = 1'b0;
    case (curReq.opcode)
      opAdd, opAddi:      signedForm = 1'b1;  // Immediate B already supplied
      opAddu, opAddui:    unsignedForm = 1'b1;
      opAddc:
      begin
        signedForm = 1'b1;
        useCarry   = 1'b1;
      end
      opAddcu, opAddcui:
      begin
        unsignedForm = 1'b1;
        useCarry     = 1'b1;
      end
      opAddci:
      begin
        signedForm = 1'b1;
        useCarry   = 1'b1;
        dropB      = 1'b1;  // A plus carry only
      end
      opSub, opSubi:
      begin
        signedForm = 1'b1;
        isSub      = 1'b1;
      end
      opCmp, opCmpi:      isCmp = 1'b1;
      default: ;  // Not ours
    endcase
  end

  ////////////////////////////////////////
  // Shared adder
  ////////////////////////////////////////

  assign opB    = isSub ? ~curReq.b : (dropB ? '0 : curReq.b);
  assign cinEff = isSub | (useCarry & carryIn);  // Two's complement +1 on subtract
  assign sum    = {1'b0, curReq.a} + {1'b0, opB} + {{wordBitsL{1'b0}}, cinEff};
  assign sumW   = sum[wordBitsL-1:0];

  // Same-sign inputs, result sign flipped
  // Inverted B makes this hold for subtract too
  assign ovf = (curReq.a[wordBitsL-1] == opB[wordBitsL-1]) &&
               (sumW[wordBitsL-1] != curReq.a[wordBitsL-1]);

  ////////////////////////////////////////
  // Result and flags
  ////////////////////////////////////////

  always_comb
  begin
    res     = '0;  // Unlisted flags stay clear
    res.hit = signedForm | unsignedForm | isCmp;
    if (signedForm || unsignedForm)
    begin
      res.c        = sumW;
      res.flags.zf = (sumW == '0);
      res.flags.cf = unsignedForm & sum[wordBitsL];  // 17th bit
      res.flags.ff = signedForm & ovf;
    end
    else if (isCmp)
    begin
      // Result stays zero for compares
      res.flags.lf = (curReq.a < curReq.b);
      res.flags.nf = ($signed(curReq.a) < $signed(curReq.b));
    end
  end

endmodule

// ==== source/logicShiftUnit.sv ====
`timescale 1ns/1ps

module logicShiftUnit
  import aluPkg::*;
(
  input  aluReqT     curReq,
  output unitResultT res
);

  logic [shiftBitsL-1:0] rawAmt;  // B low bits
  logic [shiftBitsL-1:0] shAmt;   // Zero means one
  wordT                  result;
  logic                  hit;
  logic                  keep;

  ////////////////////////////////////////
  // Shift amount
  ////////////////////////////////////////

  assign rawAmt = curReq.b[shiftBitsL-1:0];
  assign shAmt  = (rawAmt == '0) ? shiftBitsL'(1) : rawAmt;

  ////////////////////////////////////////
  // Logic and shift datapath
  ////////////////////////////////////////

  always_comb
  begin
    result = '0;
    hit    = 1'b1;  // Cleared in default
    keep   = 1'b0;
    case (curReq.opcode)
      // Bitwise on whole words
      opAnd:  result = curReq.a & curReq.b;
      opOr:   result = curReq.a | curReq.b;
      opXor:  result = curReq.a ^ curReq.b;
      opNot:  result = ~curReq.a;  // B unused

      // Left shifts fill with zeros
      opLsh, opLshi, opAlsh:
        result = curReq.a << shAmt;

      // Logical right
      opRsh, opRshi:
        result = curReq.a >> shAmt;

      // Arithmetic right, copies the sign bit
      opArsh:
        result = wordT'($signed(curReq.a) >>> shAmt);

      // Claimed here so the merge stage holds the last response
      opNop:  keep = 1'b1;

      default: hit = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Unit result
  ////////////////////////////////////////

  always_comb
  begin
    res          = '0;
    res.hit      = hit;
    res.keep     = keep;
    res.c        = result;
    res.flags.zf = hit & ~keep & (result == '0);  // Only Z from this unit
  end

endmodule

// ==== source/flagMerge.sv ====
`timescale 1ns/1ps

module flagMerge
  import aluPkg::*;
(
  input  logic       clk,
  input  logic       arstN,
  input  logic       start,     // Launch pulse from opLatch
  input  logic       req,       // Requester still holding
  input  unitResultT arithRes,
  input  unitResultT logicRes,
  output logic       carryIn,   // Stored C back to arithUnit
  output aluRespT    resp,
  output logic       ack
);

  unitResultT sel;       // Owning unit's offer
  logic       anyHit;
  logic       update;    // Write resp this edge
  logic       ackNext;

  ////////////////////////////////////////
  // Owner select
  ////////////////////////////////////////

  assign anyHit = arithRes.hit | logicRes.hit;

  // Units decode disjoint opcode sets
  always_comb
  begin
    if (arithRes.hit)
      sel = arithRes;
    else if (logicRes.hit)
      sel = logicRes;
    else
      sel = '0;  // Unknown opcode gives zero, flags clear
  end

  // NOP leaves both result and flags alone
  assign update = start & ~(anyHit & sel.keep);

  ////////////////////////////////////////
  // Ack control
  ////////////////////////////////////////

  always_comb
  begin
    ackNext = ack;
    if (start)
      ackNext = 1'b1;  // Result lands with ack
    else if (ack && !req)
      ackNext = 1'b0;  // Requester let go
  end

  ////////////////////////////////////////
  // Response and flag register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      resp <= '0;
      ack  <= 1'b0;
    end
    else
    begin
      ack <= ackNext;
      if (update)
      begin
        resp.c     <= sel.c;
        resp.flags <= sel.flags;
      end
    end
  end

  // Carry chains into the next ADDC family op
  assign carryIn = resp.flags.cf;

endmodule

// ==== source/aluExecUnit.sv ====
`timescale 1ns/1ps

module aluExecUnit
  import aluPkg::*;
(
  input  logic    clk,
  input  logic    arstN,
  input  logic    req,      // Four-phase request
  input  aluReqT  reqData,
  output logic    ack,
  output aluRespT resp      // Valid from ack until next ack
);

  aluReqT     curReq;    // Latched operation
  logic       start;
  logic       carryIn;   // Stored C flag
  unitResultT arithRes;
  unitResultT logicRes;

  // Request side
  opLatch u_opLatch (
    .clk     (clk),
    .arstN   (arstN),
    .req     (req),
    .reqData (reqData),
    .ack     (ack),
    .curReq  (curReq),
    .start   (start)
  );

  // Add, subtract, compare
  arithUnit u_arithUnit (
    .curReq  (curReq),
    .carryIn (carryIn),
    .res     (arithRes)
  );

  // Bitwise, shifts, NOP
  logicShiftUnit u_logicShiftUnit (
    .curReq (curReq),
    .res    (logicRes)
  );

  // Response register and ack
  flagMerge u_flagMerge (
    .clk      (clk),
    .arstN    (arstN),
    .start    (start),
    .req      (req),
    .arithRes (arithRes),
    .logicRes (logicRes),
    .carryIn  (carryIn),
    .resp     (resp),
    .ack      (ack)
  );

endmodule

// ==== include/aluRefModel.svh ====
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

////////////////////////////////////////
// Expected response for one operation
////////////////////////////////////////

function automatic aluRespT refAlu(input aluReqT r, input aluRespT prev);
  aluRespT            o;
  wordT               a;
  wordT               bx;      // Second operand after form rules
  logic [wordBitsL:0] wide;    // Sum with carry out
  logic               cin;
  int                 amt;
  o    = '0;
  a    = r.a;
  bx   = r.b;
  cin  = 1'b0;
  amt  = (r.b[shiftBitsL-1:0] == '0) ? 1 : int'(r.b[shiftBitsL-1:0]);  // Zero means one
  case (r.opcode)
    opAdd, opAddi, opAddc, opAddci:
    begin
      if (r.opcode == opAddci)
        bx = '0;  // A plus carry only
      if (r.opcode == opAddc || r.opcode == opAddci)
        cin = prev.flags.cf;
      wide = {1'b0, a} + {1'b0, bx} + {{wordBitsL{1'b0}}, cin};
      o.c = wide[wordBitsL-1:0];
      o.flags.ff = (a[15] == bx[15]) && (o.c[15] != a[15]);
      o.flags.zf = (o.c == '0);
    end
    opAddu, opAddui, opAddcu, opAddcui:
    begin
      if (r.opcode == opAddcu || r.opcode == opAddcui)
        cin = prev.flags.cf;
      wide = {1'b0, a} + {1'b0, bx} + {{wordBitsL{1'b0}}, cin};
      o.c        = wide[wordBitsL-1:0];
      o.flags.cf = wide[wordBitsL];  // 17th bit
      o.flags.zf = (o.c == '0);
    end
    opSub, opSubi:
    begin
      o.c = a - bx;
      o.flags.ff = (a[15] != bx[15]) && (o.c[15] != a[15]);  // Opposite signs, sign flipped
      o.flags.zf = (o.c == '0);
    end
    opCmp, opCmpi:
    begin
      o.flags.lf = (a < bx);
      o.flags.nf = ($signed(a) < $signed(bx));
    end
    opAnd:  o.c = a & bx;
    opOr:   o.c = a | bx;
    opXor:  o.c = a ^ bx;
    opNot:  o.c = ~a;
    opLsh, opLshi, opAlsh: o.c = a << amt;
    opRsh, opRshi:         o.c = a >> amt;
    opArsh:
    begin
      o.c = a;
      for (int i = 0; i < amt; i++)
        o.c = {o.c[15], o.c[15:1]};  // Sign bit copied in
    end
    opNop:  o = prev;
    default: o = '0;
  endcase
  // Logic and shift ops only report Z
  if (r.opcode inside {opAnd, opOr, opXor, opNot, opLsh, opLshi, opAlsh, opRsh, opRshi, opArsh})
    o.flags.zf = (o.c == '0);
  return o;
endfunction

////////////////////////////////////////
// Galois LFSR, x^32+x^22+x^2+x+1
////////////////////////////////////////

function automatic logic [31:0] lfsrNext(input logic [31:0] s);
  if (s[0])
    return (s >> 1) ^ 32'h8020_0003;
  else
    return s >> 1;
endfunction

`endif

// ==== bench/aluExecUnitTb.sv ====
`timescale 1ns/1ps

module aluExecUnitTb
  import aluPkg::*;
();

  localparam int ackTimeoutL = 50;       // Negedges allowed per handshake wait
  localparam logic [31:0] seedL = 32'hc923_bdbd;

  logic    clk = 1'b0;  // Low before any process starts
  logic    arstN;
  logic    req;
  aluReqT  reqData;
  logic    ack;
  aluRespT resp;

  logic [31:0] lfsrState;
  aluRespT     modelResp;    // Model's previous response
  aluRespT     lastResp;     // DUT response at the last ack
  int          lastAckWait;
  int          lastDropWait;

  // Pending comparisons
  string   nameQ[$];
  aluRespT expQ[$];
  aluRespT actQ[$];

  `include "aluRefModel.svh"

  aluExecUnit u_aluExecUnit (
    .clk     (clk),
    .arstN   (arstN),
    .req     (req),
    .reqData (reqData),
    .ack     (ack),
    .resp    (resp)
  );

  initial
  begin
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Failure and compare tasks
  ////////////////////////////////////////

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic checkResp(input string name, input aluRespT exp, input aluRespT act);
    if (act !== exp)
    begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      reportFailure("Response mismatch");
    end
  endtask

  task automatic checkFlags(input string name, input flagsT exp, input flagsT act);
    if (act !== exp)
    begin
      $display("ERROR %s expected %b actual %b", name, exp, act);
      reportFailure("Flag mismatch");
    end
  endtask

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsrState[0]};  // One step per bit
      lfsrState = lfsrNext(lfsrState);
    end
    return v;
  endfunction

  function automatic aluRespT mkResp(input wordT c, input flagsT f);
    aluRespT r;
    r.c     = c;
    r.flags = f;
    return r;
  endfunction

  // Comparing process drains the queues on every falling edge
  initial
  begin
    forever
    begin
      @(negedge clk);
      while (actQ.size() > 0)
        checkResp(nameQ.pop_front(), expQ.pop_front(), actQ.pop_front());
    end
  end

  ////////////////////////////////////////
  // Four-phase handshake driver
  ////////////////////////////////////////

  task automatic runOp(input string name, input opcodeE op, input wordT a, input wordT b,
                       input int hold);
    aluReqT  r;
    aluRespT exp;
    aluRespT held;
    int      waitCnt;
    @(negedge clk);
    r.opcode  = op;
    r.a       = a;
    r.b       = b;
    exp       = refAlu(r, modelResp);
    modelResp = exp;
    reqData   = r;
    req       = 1'b1;
    waitCnt   = 0;
    while (!ack)
    begin
      @(negedge clk);
      waitCnt++;
      if (waitCnt > ackTimeoutL)
        reportFailure($sformatf("Timeout: ack never rose for %s", name));
    end
    lastAckWait = waitCnt;
    lastResp    = resp;
    held        = resp;
    nameQ.push_back(name);
    expQ.push_back(exp);
    actQ.push_back(resp);
    repeat (hold)  // Back-pressure with req kept high
    begin
      @(negedge clk);
      if (!ack)
        reportFailure($sformatf("ack dropped while req still high in %s", name));
      checkResp({name, " held"}, held, resp);
    end
    req     = 1'b0;
    waitCnt = 0;
    while (ack)
    begin
      @(negedge clk);
      waitCnt++;
      if (waitCnt > ackTimeoutL)
        reportFailure($sformatf("Timeout: ack never fell for %s", name));
    end
    lastDropWait = waitCnt;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial
  begin
    opcodeE logicOps[10];
    int     idx;
    int     waitCnt;
    logicOps  = '{opAnd, opOr, opXor, opNot, opLsh, opLshi, opAlsh, opRsh, opRshi, opArsh};
    req       = 1'b0;
    reqData   = '0;
    arstN     = 1'b0;
    lfsrState = seedL;
    modelResp = '0;
    repeat (2) @(negedge clk);
    arstN = 1'b1;

    // Reset state and fixed latency
    checkResp("reset resp", '0, resp);
    if (ack !== 1'b0)
      reportFailure("ack is not low after reset");
    runOp("first add", opAdd, 16'h0001, 16'h0002, 0);
    if (lastAckWait != 3)  // Three falling edges from raise to ack means 2 edges after sampling
      reportFailure($sformatf("First ack latency wrong, waited %0d falling edges", lastAckWait));

    // Directed arithmetic
    runOp("add overflow", opAdd, 16'h7fff, 16'h0001, 0);
    checkResp("add overflow value", mkResp(16'h8000, flagsT'(5'b00100)), lastResp);
    runOp("addu carry", opAddu, 16'hffff, 16'h0001, 0);
    checkFlags("addu carry flags", flagsT'(5'b11000), lastResp.flags);
    runOp("addc chained", opAddc, 16'h0001, 16'h0002, 0);
    checkResp("addc value", mkResp(16'h0004, flagsT'(5'b00000)), lastResp);
    runOp("addu carry again", opAddu, 16'hffff, 16'h0001, 0);
    runOp("addci chained", opAddci, 16'h0010, 16'h1234, 0);
    checkResp("addci value", mkResp(16'h0011, flagsT'(5'b00000)), lastResp);
    runOp("sub negative", opSub, 16'h0005, 16'h0007, 0);
    checkResp("sub value", mkResp(16'hfffe, flagsT'(5'b00000)), lastResp);
    runOp("cmp mixed sign", opCmp, 16'h8000, 16'h0001, 0);
    checkFlags("cmp signed less", flagsT'(5'b00001), lastResp.flags);
    runOp("cmpi mixed sign", opCmpi, 16'h0001, 16'hffff, 0);
    checkFlags("cmpi unsigned less", flagsT'(5'b00010), lastResp.flags);

    // Bitwise and shifts
    for (int round = 0; round < 4; round++)
      foreach (logicOps[i])
        runOp($sformatf("logic %s", logicOps[i].name()), logicOps[i],
              wordT'(randBits(16)), wordT'(randBits(16)), 0);
    runOp("lsh amount zero", opLsh, 16'h0001, 16'h0010, 0);
    checkResp("lsh amount zero value", mkResp(16'h0002, flagsT'(5'b00000)), lastResp);
    runOp("arsh negative", opArsh, 16'h8000, 16'h0003, 0);
    checkResp("arsh value", mkResp(16'hf000, flagsT'(5'b00000)), lastResp);
    runOp("rsh negative", opRsh, 16'h8000, 16'h0003, 0);
    checkResp("rsh value", mkResp(16'h1000, flagsT'(5'b00000)), lastResp);

    // NOP and unknown opcodes
    runOp("nop keeps", opNop, 16'haaaa, 16'h5555, 0);
    checkResp("nop value", mkResp(16'h1000, flagsT'(5'b00000)), lastResp);
    runOp("unknown 200", opcodeE'(8'd200), 16'hffff, 16'hffff, 0);
    checkResp("unknown value", '0, lastResp);
    runOp("unknown 3", opcodeE'(8'd3), 16'h1234, 16'h4321, 0);

    // Held ADDC where a second launch would give 2 instead of 3
    runOp("addu set carry", opAddu, 16'hffff, 16'h0001, 0);
    runOp("addc held", opAddc, 16'h0001, 16'h0001, 6);
    if (lastDropWait != 1)
      reportFailure($sformatf("ack fell %0d cycles after req dropped", lastDropWait));
    checkResp("addc after hold", mkResp(16'h0003, flagsT'(5'b00000)), resp);

    // Random operations with carry chaining
    for (int n = 0; n < 200; n++)
    begin
      idx = int'(randBits(5)) % 24;  // 23 gives an unknown opcode
      runOp($sformatf("random %0d", n), opcodeE'(8'(idx * 8)),
            wordT'(randBits(16)), wordT'(randBits(16)), int'(randBits(2)));
    end

    waitCnt = 0;
    while (actQ.size() > 0)
    begin
      @(negedge clk);
      waitCnt++;
      if (waitCnt > ackTimeoutL)
        reportFailure("Compare queue never drained");
    end
    @(negedge clk);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+include
source/aluPkg.sv
source/opLatch.sv
source/arithUnit.sv
source/logicShiftUnit.sv
source/flagMerge.sv
source/aluExecUnit.sv
bench/aluExecUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ALU execute unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f build.f --top-module aluExecUnitTb -o simv

status=0
output=$(./obj_dir/simv 2>&1) || status=$?
echo "$output"

if echo "$output" | grep -q "TESTS PASSED"; then
  exit 0
else
  echo "Simulation exit status: $status"
  exit 1
fi
